// ==== soc_top.f ====
+incdir+rtl
rtl/soc_map_pkg.sv
rtl/soc_bus_pkg.sv
rtl/addr_decoder.sv
rtl/stream_fifo.sv
rtl/apb_master.sv
rtl/ctrl_registers.sv
rtl/soc_target.sv
rtl/soc_top.sv
testbench/soc_top_checker.sv
testbench/soc_top_tb.sv

// ==== testbench/soc_top_tb.sv ====
// Memory fabric testbench with request table, APB responder model and response checks
`include "soc_macros.svh"

module soc_top_tb
  import soc_map_pkg::*;
();

  localparam int          CLK_HALF   = 20;
  localparam int          DRIVE_DLY  = 2;
  localparam int          TIMEOUT    = 2000;
  localparam int          WAIT_SLOTS = 64;
  localparam logic [31:0] SEED       = 32'h2a42a7db;

  typedef struct {
    string                  name;
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
    logic [`SOC_DATA_W-1:0] exp_rdata;
    logic                   exp_err;
    logic                   bp;
  } test_entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  logic [`SOC_ADDR_W-1:0] req_addr;
  logic                   req_we;
  logic [`SOC_DATA_W-1:0] req_wdata;
  logic [`SOC_STRB_W-1:0] req_strb;
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`SOC_DATA_W-1:0] rsp_rdata;
  logic                   rsp_err;
  logic [`SOC_DATA_W-1:0] exit_val;
  logic                   uart_psel;
  logic                   uart_penable;
  logic                   uart_pwrite;
  logic [`SOC_ADDR_W-1:0] uart_paddr;
  logic [`SOC_DATA_W-1:0] uart_pwdata;
  logic [`SOC_DATA_W-1:0] uart_prdata;
  logic                   uart_pready;
  logic                   uart_pslverr;

  test_entry_t            tests [$];
  int                     error_count = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  bit                     timed_out = 0;
  bit                     bp_active = 0;
  bit                     bp_armed = 0;

  // APB responder state
  int unsigned            apb_waits [WAIT_SLOTS];
  int unsigned            apb_xfers = 0;
  int unsigned            apb_wait = 0;
  logic [3:0]             apb_idx;
  logic [`SOC_DATA_W-1:0] apb_mem [16];
  bit                     apb_written [16];
  logic [63:0]            apb_log [$];

  soc_top soc_top_i (
    .clk_i         (clk         ),
    .rst_n_i       (rst_n       ),
    .req_valid_i   (req_valid   ),
    .req_ready_o   (req_ready   ),
    .req_addr_i    (req_addr    ),
    .req_we_i      (req_we      ),
    .req_wdata_i   (req_wdata   ),
    .req_strb_i    (req_strb    ),
    .rsp_valid_o   (rsp_valid   ),
    .rsp_ready_i   (rsp_ready   ),
    .rsp_rdata_o   (rsp_rdata   ),
    .rsp_err_o     (rsp_err     ),
    .exit_o        (exit_val    ),
    .uart_psel_o   (uart_psel   ),
    .uart_penable_o(uart_penable),
    .uart_pwrite_o (uart_pwrite ),
    .uart_paddr_o  (uart_paddr  ),
    .uart_pwdata_o (uart_pwdata ),
    .uart_prdata_i (uart_prdata ),
    .uart_pready_i (uart_pready ),
    .uart_pslverr_i(uart_pslverr)
  );

  bind soc_top soc_top_checker i_soc_top_checker (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .rsp_valid_i(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_rdata_i(rsp_rdata_o),
    .rsp_err_i  (rsp_err_o  ),
    .psel_i     (uart_psel_o),
    .penable_i  (uart_penable_o),
    .exit_i     (exit_o     )
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////
  // APB responder
  ////////////////////

  always @(posedge clk) begin
    #DRIVE_DLY;
    uart_pready  = 1'b0;
    uart_pslverr = 1'b0;
    uart_prdata  = '0;
    apb_idx      = uart_paddr[5:2];
    if (uart_psel && !uart_penable) begin
      apb_wait  = apb_waits[apb_xfers % WAIT_SLOTS];
      apb_xfers = apb_xfers + 1;
    end else if (uart_psel && uart_penable) begin
      if (apb_wait != 0) begin
        apb_wait = apb_wait - 1;
      end else begin
        uart_pready = 1'b1;
        if (uart_pwrite) begin
          apb_log.push_back({uart_paddr, uart_pwdata});
        end
        if (uart_paddr >= 32'h800) begin
          uart_pslverr = 1'b1;
        end else if (uart_pwrite) begin
          apb_mem[apb_idx]     = uart_pwdata;
          apb_written[apb_idx] = 1'b1;
        end else begin
          // Unwritten words read back a pattern of the full address
          uart_prdata = apb_written[apb_idx] ? apb_mem[apb_idx] : (uart_paddr ^ 32'hA5A5_0000);
        end
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic add_entry(input string name, input logic [31:0] addr, input logic we,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic [31:0] exp_rdata, input logic exp_err, input logic bp);
    tests.push_back('{name, addr, we, wdata, strb, exp_rdata, exp_err, bp});
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%-20s passed", name);
    end else begin
      tests_failed++;
      $display("%-20s FAILED", name);
    end
  endtask

  task automatic send_request(input test_entry_t t);
    int waited;
    waited    = 0;
    req_valid = 1'b1;
    req_addr  = t.addr;
    req_we    = t.we;
    req_wdata = t.wdata;
    req_strb  = t.strb;
    @(negedge clk);
    while (!req_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      $display("Timeout: request %s was never accepted", t.name);
      error_count++;
      timed_out = 1;
    end
    @(posedge clk);
    #DRIVE_DLY;
    req_valid = 1'b0;
  endtask

  task automatic drive_requests();
    foreach (tests[i]) begin
      if (timed_out) begin
        break;
      end
      // Stall phase starts once, at the first flagged entry
      if (tests[i].bp && !bp_armed) begin
        bp_armed  = 1;
        bp_active = 1;
      end
      send_request(tests[i]);
    end
  endtask

  task automatic collect_responses();
    int got;
    int idle;
    int errs_before;
    got  = 0;
    idle = 0;
    while (got < tests.size() && !timed_out) begin
      @(posedge clk);
      #DRIVE_DLY;
      rsp_ready = bp_active ? 1'b0 : ($urandom_range(3, 0) != 0);
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        idle        = 0;
        errs_before = error_count;
        check_value({tests[got].name, " rdata"}, tests[got].exp_rdata, rsp_rdata);
        check_value({tests[got].name, " err"}, {31'b0, tests[got].exp_err}, {31'b0, rsp_err});
        if (tests[got].we && tests[got].addr == `SOC_CTRL_BASE + CTRL_EXIT) begin
          check_value({tests[got].name, " exit_o"}, tests[got].wdata, exit_val);
        end
        report_test(tests[got].name, errs_before);
        got++;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout: no response for test %s", tests[got].name);
          error_count++;
          timed_out = 1;
        end
      end
    end
  endtask

  // Hold responses until the whole pipeline is full
  task automatic release_backpressure();
    int waited;
    waited = 0;
    while (!bp_active && !timed_out && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!bp_active) begin
      if (!timed_out) begin
        $display("Timeout: back-pressure phase never started");
        error_count++;
        timed_out = 1;
      end
      return;
    end
    waited = 0;
    @(negedge clk);
    while (req_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (req_ready) begin
      $display("req_ready_o never dropped while responses were held back");
      error_count++;
    end
    @(posedge clk);
    #DRIVE_DLY;
    bp_active = 0;
  endtask

  task automatic check_apb_writes();
    logic [63:0] expected [$];
    int          errs_before;
    errs_before = error_count;
    foreach (tests[i]) begin
      if (tests[i].we && tests[i].addr >= `SOC_UART_BASE &&
          tests[i].addr < `SOC_UART_BASE + `SOC_UART_LEN) begin
        expected.push_back({tests[i].addr - `SOC_UART_BASE, tests[i].wdata});
      end
    end
    check_value("apb_write_log count", expected.size(), apb_log.size());
    foreach (expected[i]) begin
      if (i < apb_log.size()) begin
        check_value("apb_write_log paddr", expected[i][63:32], apb_log[i][63:32]);
        check_value("apb_write_log pwdata", expected[i][31:0], apb_log[i][31:0]);
      end
    end
    report_test("apb_write_log", errs_before);
  endtask

  task automatic build_table();
    add_entry("l2_full_wr",       32'h8000_0010, 1, 32'hDEAD_BEEF, 4'hF, 32'h0, 0, 0);
    add_entry("l2_part_wr",       32'h8000_0010, 1, 32'h1122_3344, 4'h5, 32'h0, 0, 0);
    add_entry("l2_merge_rd",      32'h8000_0010, 0, 32'h0, 4'hF, 32'hDE22_BE44, 0, 0);
    add_entry("ctrl_exit_wr",     32'hD000_0000, 1, 32'h0000_002A, 4'hF, 32'h0, 0, 0);
    add_entry("ctrl_exit_rd",     32'hD000_0000, 0, 32'h0, 4'hF, 32'h0000_002A, 0, 0);
    add_entry("ctrl_base_wr",     32'hD000_0004, 1, 32'h1234_5678, 4'hF, 32'h0, 0, 0);
    add_entry("ctrl_base_rd",     32'hD000_0004, 0, 32'h0, 4'hF, 32'h8000_0000, 0, 0);
    add_entry("ctrl_end_wr",      32'hD000_0008, 1, 32'hFFFF_FFFF, 4'hF, 32'h0, 0, 0);
    add_entry("ctrl_end_rd",      32'hD000_0008, 0, 32'h0, 4'hF, 32'h8000_0400, 0, 0);
    add_entry("ctrl_undef_rd",    32'hD000_0010, 0, 32'h0, 4'hF, 32'h0, 1, 0);
    add_entry("uart_wr",          32'hC000_0024, 1, 32'hCAFE_0001, 4'hF, 32'h0, 0, 0);
    add_entry("uart_rd",          32'hC000_0024, 0, 32'h0, 4'hF, 32'hCAFE_0001, 0, 0);
    add_entry("uart_fresh_rd",    32'hC000_0030, 0, 32'h0, 4'hF, 32'hA5A5_0030, 0, 0);
    add_entry("uart_err_rd",      32'hC000_0800, 0, 32'h0, 4'hF, 32'h0, 1, 0);
    add_entry("unmapped_rd",      32'h0000_1000, 0, 32'h0, 4'hF, 32'h0, 1, 0);
    // Twelve requests overflow the ten pipeline slots
    add_entry("bp_l2_wr_a",       32'h8000_0100, 1, 32'h0102_0304, 4'hF, 32'h0, 0, 1);
    add_entry("bp_uart_wr",       32'hC000_0008, 1, 32'h5555_AAAA, 4'hF, 32'h0, 0, 1);
    add_entry("bp_l2_rd_a",       32'h8000_0100, 0, 32'h0, 4'hF, 32'h0102_0304, 0, 1);
    add_entry("bp_bench_wr",      32'hD000_000C, 1, 32'h0BAD_F00D, 4'h3, 32'h0, 0, 1);
    add_entry("bp_bench_rd",      32'hD000_000C, 0, 32'h0, 4'hF, 32'h0000_F00D, 0, 1);
    add_entry("bp_uart_rd",       32'hC000_0008, 0, 32'h0, 4'hF, 32'h5555_AAAA, 0, 1);
    add_entry("bp_unmapped_wr",   32'h4000_0000, 1, 32'h0000_0001, 4'hF, 32'h0, 1, 1);
    add_entry("bp_l2_rd_b",       32'h8000_0010, 0, 32'h0, 4'hF, 32'hDE22_BE44, 0, 1);
    add_entry("bp_ctrl_base_rd",  32'hD000_0004, 0, 32'h0, 4'hF, 32'h8000_0000, 0, 1);
    add_entry("bp_uart_err_wr",   32'hC000_0900, 1, 32'h0000_0007, 4'hF, 32'h0, 1, 1);
    add_entry("bp_l2_wr_b",       32'h8000_0100, 1, 32'h89AB_CDEF, 4'h8, 32'h0, 0, 1);
    add_entry("bp_l2_rd_c",       32'h8000_0100, 0, 32'h0, 4'hF, 32'h8902_0304, 0, 1);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int errs_before;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_we       = 1'b0;
    req_wdata    = '0;
    req_strb     = '0;
    rsp_ready    = 1'b0;
    uart_prdata  = '0;
    uart_pready  = 1'b0;
    uart_pslverr = 1'b0;
    void'($urandom(SEED));
    foreach (apb_waits[i]) begin
      apb_waits[i] = $urandom_range(3, 0);
    end
    build_table();

    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    @(negedge clk);
    errs_before = error_count;
    check_value("reset req_ready_o", 32'd1, {31'b0, req_ready});
    check_value("reset rsp_valid_o", 32'd0, {31'b0, rsp_valid});
    check_value("reset uart_psel_o", 32'd0, {31'b0, uart_psel});
    check_value("reset uart_penable_o", 32'd0, {31'b0, uart_penable});
    check_value("reset exit_o", 32'd0, exit_val);
    report_test("reset_state", errs_before);

    @(posedge clk);
    #DRIVE_DLY;
    fork
      drive_requests();
      collect_responses();
      release_backpressure();
    join
    check_apb_writes();

    $display("Summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, error_count, soc_top_i.i_soc_top_checker.fail_count);
    if (error_count == 0 && soc_top_i.i_soc_top_checker.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== testbench/soc_top_checker.sv ====
// Concurrent protocol assertions for the response port, the APB pins and exit_o
`include "soc_macros.svh"

module soc_top_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   rsp_valid_i,
  input logic                   rsp_ready_i,
  input logic [`SOC_DATA_W-1:0] rsp_rdata_i,
  input logic                   rsp_err_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic [`SOC_DATA_W-1:0] exit_i
);

  int unsigned fail_count = 0;

  // Stalled response keeps valid and payload
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
    else begin
      fail_count++;
      $error("rsp_valid_o or its data changed before rsp_ready_i");
    end

  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i)
    else begin
      fail_count++;
      $error("uart_penable_o high without uart_psel_o");
    end

  // Setup phase lasts exactly one cycle
  a_setup_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(psel_i) |=> penable_i)
    else begin
      fail_count++;
      $error("uart_penable_o did not follow uart_psel_o by one cycle");
    end

  a_exit_reset: assert property (@(posedge clk_i)
    !rst_n_i ##1 !rst_n_i |-> exit_i == '0)
    else begin
      fail_count++;
      $error("exit_o not zero during reset");
    end

endmodule

// ==== rtl/soc_top.sv ====
// Memory fabric top level with decoder, request and response queues and target
`include "soc_macros.svh"

module soc_top
  import soc_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_strb_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`SOC_DATA_W-1:0] uart_pwdata_o,
  input  logic [`SOC_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);

  dec_req_t dec_req;
  logic     dec_valid;
  logic     dec_ready;
  dec_req_t tgt_req;
  logic     tgt_req_valid;
  logic     tgt_req_ready;
  bus_rsp_t tgt_rsp;
  logic     tgt_rsp_valid;
  logic     tgt_rsp_ready;
  bus_rsp_t out_rsp;

  assign rsp_rdata_o = out_rsp.rdata;
  assign rsp_err_o   = out_rsp.err;

  addr_decoder i_addr_decoder (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .in_valid_i (req_valid_i),
    .in_addr_i  (req_addr_i ),
    .in_we_i    (req_we_i   ),
    .in_wdata_i (req_wdata_i),
    .in_strb_i  (req_strb_i ),
    .in_ready_o (req_ready_o),
    .out_valid_o(dec_valid  ),
    .out_req_o  (dec_req    ),
    .out_ready_i(dec_ready  )
  );

  stream_fifo #(
    .DEPTH    (`SOC_QUEUE_DEPTH),
    .payload_t(dec_req_t       )
  ) i_req_queue (
    .clk_i       (clk_i        ),
    .rst_n_i     (rst_n_i      ),
    .push_valid_i(dec_valid    ),
    .push_data_i (dec_req      ),
    .push_ready_o(dec_ready    ),
    .pop_valid_o (tgt_req_valid),
    .pop_data_o  (tgt_req      ),
    .pop_ready_i (tgt_req_ready)
  );

  soc_target i_soc_target (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .req_valid_i   (tgt_req_valid ),
    .req_i         (tgt_req       ),
    .req_ready_o   (tgt_req_ready ),
    .rsp_valid_o   (tgt_rsp_valid ),
    .rsp_o         (tgt_rsp       ),
    .rsp_ready_i   (tgt_rsp_ready ),
    .exit_o        (exit_o        ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  stream_fifo #(
    .DEPTH    (`SOC_QUEUE_DEPTH),
    .payload_t(bus_rsp_t       )
  ) i_rsp_queue (
    .clk_i       (clk_i        ),
    .rst_n_i     (rst_n_i      ),
    .push_valid_i(tgt_rsp_valid),
    .push_data_i (tgt_rsp      ),
    .push_ready_o(tgt_rsp_ready),
    .pop_valid_o (rsp_valid_o  ),
    .pop_data_o  (out_rsp      ),
    .pop_ready_i (rsp_ready_i  )
  );

endmodule

// ==== rtl/soc_target.sv ====
// Target engine running L2, control and UART accesses and building responses
`include "soc_macros.svh"

module soc_target
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  dec_req_t               req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output bus_rsp_t               rsp_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`SOC_DATA_W-1:0] uart_pwdata_o,
  input  logic [`SOC_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);

  localparam int unsigned L2_AW   = $clog2(`SOC_L2_WORDS);
  localparam int unsigned BYTE_AW = $clog2(`SOC_STRB_W);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } state_e;

  state_e                 state_q;
  region_e                region_q;
  logic                   we_q;
  logic                   pop;
  logic [L2_AW-1:0]       l2_idx;
  logic [`SOC_DATA_W-1:0] l2_mem [`SOC_L2_WORDS];
  logic [`SOC_DATA_W-1:0] l2_rdata_q;
  logic                   ctrl_access;
  logic [`SOC_DATA_W-1:0] ctrl_rdata;
  logic                   ctrl_err;
  logic                   apb_start;
  logic                   apb_done;
  logic [`SOC_DATA_W-1:0] apb_rdata;
  logic                   apb_err;

  // One request at a time
  assign req_ready_o = (state_q == ST_IDLE);
  assign pop         = req_valid_i && req_ready_o;
  assign l2_idx      = req_i.offset[BYTE_AW +: L2_AW];
  assign ctrl_access = pop && (req_i.region == REGION_CTRL);
  assign apb_start   = pop && (req_i.region == REGION_UART);

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop && req_i.region == REGION_UART) begin
            state_q <= ST_BUSY;
          end else if (pop) begin
            state_q <= ST_HOLD;
          end
        end
        ST_BUSY: begin
          if (apb_done && rsp_ready_i) begin
            state_q <= ST_IDLE;
          end else if (apb_done) begin
            state_q <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (rsp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      region_q <= req_i.region;
      we_q     <= req_i.we;
    end
  end

  ////////////////////
  // L2 memory
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (pop && req_i.region == REGION_L2) begin
      if (req_i.we) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (req_i.strb[b]) begin
            l2_mem[l2_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      l2_rdata_q <= l2_mem[l2_idx];
    end
  end

  ////////////////////
  // Peripherals
  ////////////////////

  ctrl_registers i_ctrl_registers (
    .clk_i   (clk_i        ),
    .rst_n_i (rst_n_i      ),
    .access_i(ctrl_access  ),
    .write_i (req_i.we     ),
    .offset_i(req_i.offset ),
    .wdata_i (req_i.wdata  ),
    .strb_i  (req_i.strb   ),
    .rdata_o (ctrl_rdata   ),
    .err_o   (ctrl_err     ),
    .exit_o  (exit_o       )
  );

  apb_master i_apb_master (
    .clk_i    (clk_i         ),
    .rst_n_i  (rst_n_i       ),
    .start_i  (apb_start     ),
    .write_i  (req_i.we      ),
    .addr_i   (req_i.offset  ),
    .wdata_i  (req_i.wdata   ),
    .done_o   (apb_done      ),
    .rdata_o  (apb_rdata     ),
    .err_o    (apb_err       ),
    .psel_o   (uart_psel_o   ),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o ),
    .paddr_o  (uart_paddr_o  ),
    .pwdata_o (uart_pwdata_o ),
    .prdata_i (uart_prdata_i ),
    .pready_i (uart_pready_i ),
    .pslverr_i(uart_pslverr_i)
  );

  // UART result is offered the cycle done pulses
  assign rsp_valid_o = (state_q == ST_HOLD) || (state_q == ST_BUSY && apb_done);

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b0;
    case (region_q)
      REGION_L2:   rsp_o.rdata = l2_rdata_q;
      REGION_CTRL: begin
        rsp_o.rdata = ctrl_rdata;
        rsp_o.err   = ctrl_err;
      end
      REGION_UART: begin
        rsp_o.rdata = apb_rdata;
        rsp_o.err   = apb_err;
      end
      default:     rsp_o.err = 1'b1;
    endcase
    if (we_q) begin
      rsp_o.rdata = '0;
    end
  end

endmodule

// ==== rtl/ctrl_registers.sv ====
// Exit, benchmark and read-only DRAM range control registers
`include "soc_macros.svh"

module ctrl_registers
  import soc_map_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   access_i,
  input  logic                   write_i,
  input  logic [`SOC_ADDR_W-1:0] offset_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_STRB_W-1:0] strb_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   err_o,
  output logic [`SOC_DATA_W-1:0] exit_o
);

  localparam logic [`SOC_DATA_W-1:0] DRAM_BASE = `SOC_DRAM_BASE;
  localparam logic [`SOC_DATA_W-1:0] DRAM_END  = `SOC_DRAM_BASE + `SOC_DRAM_LEN;

  logic [`SOC_DATA_W-1:0] bench_q;
  logic [`SOC_DATA_W-1:0] rdata_d;
  logic                   err_d;

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (offset_i)
      CTRL_EXIT:      rdata_d = exit_o;
      CTRL_DRAM_BASE: rdata_d = DRAM_BASE;
      CTRL_DRAM_END:  rdata_d = DRAM_END;
      CTRL_BENCH:     rdata_d = bench_q;
      default:        err_d   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_o  <= '0;
      bench_q <= '0;
    end else if (access_i && write_i) begin
      // DRAM range offsets ignore writes
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (strb_i[b] && offset_i == CTRL_EXIT) begin
          exit_o[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (strb_i[b] && offset_i == CTRL_BENCH) begin
          bench_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_i) begin
      rdata_o <= rdata_d;
      err_o   <= err_d;
    end
  end

endmodule

// ==== rtl/apb_master.sv ====
// APB sequencer running one setup and one access phase per start
`include "soc_macros.svh"

module apb_master (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  logic                   write_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  output logic                   done_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   err_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`SOC_ADDR_W-1:0] paddr_o,
  output logic [`SOC_DATA_W-1:0] pwdata_o,
  input  logic [`SOC_DATA_W-1:0] prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i
);

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q;

  assign psel_o    = (state_q != APB_IDLE);
  assign penable_o = (state_q == APB_ACCESS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= APB_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        APB_IDLE: begin
          if (start_i) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: state_q <= APB_ACCESS;
        APB_ACCESS: begin
          // Wait states until the slave answers
          if (pready_i) begin
            state_q <= APB_IDLE;
            done_o  <= 1'b1;
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == APB_IDLE && start_i) begin
      pwrite_o <= write_i;
      paddr_o  <= addr_i;
      pwdata_o <= wdata_i;
    end
    if (state_q == APB_ACCESS && pready_i) begin
      rdata_o <= prdata_i;
      err_o   <= pslverr_i;
    end
  end

endmodule

// ==== rtl/stream_fifo.sv ====
// Valid/ready FIFO with a type-parameter payload, no fall-through
`include "soc_macros.svh"

module stream_fifo #(
  parameter int unsigned DEPTH     = `SOC_QUEUE_DEPTH,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== rtl/addr_decoder.sv ====
// Registered address decode stage mapping requests onto memory regions
`include "soc_macros.svh"

module addr_decoder
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   in_valid_i,
  input  logic [`SOC_ADDR_W-1:0] in_addr_i,
  input  logic                   in_we_i,
  input  logic [`SOC_DATA_W-1:0] in_wdata_i,
  input  logic [`SOC_STRB_W-1:0] in_strb_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output dec_req_t               out_req_o,
  input  logic                   out_ready_i
);

  bus_req_t               in_req;
  dec_req_t               dec;
  logic [`SOC_ADDR_W-1:0] dram_off;
  logic [`SOC_ADDR_W-1:0] uart_off;
  logic [`SOC_ADDR_W-1:0] ctrl_off;

  assign in_req = '{addr: in_addr_i, we: in_we_i, wdata: in_wdata_i, strb: in_strb_i};

  // Offsets wrap below the base, so one compare covers both bounds
  assign dram_off = in_req.addr - `SOC_DRAM_BASE;
  assign uart_off = in_req.addr - `SOC_UART_BASE;
  assign ctrl_off = in_req.addr - `SOC_CTRL_BASE;

  always_comb begin
    dec.region = REGION_NONE;
    dec.offset = in_req.addr;
    dec.we     = in_req.we;
    dec.wdata  = in_req.wdata;
    dec.strb   = in_req.strb;
    if (dram_off < `SOC_DRAM_LEN) begin
      dec.region = REGION_L2;
      dec.offset = dram_off;
    end else if (uart_off < `SOC_UART_LEN) begin
      dec.region = REGION_UART;
      dec.offset = uart_off;
    end else if (ctrl_off < `SOC_CTRL_LEN) begin
      dec.region = REGION_CTRL;
      dec.offset = ctrl_off;
    end
  end

  // Stage accepts when empty or draining this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      out_req_o <= dec;
    end
  end

endmodule

// ==== rtl/soc_bus_pkg.sv ====
// Request, decoded request and response payload types
`include "soc_macros.svh"

package soc_bus_pkg;

  import soc_map_pkg::*;

  // Upstream request as it arrives on the pins
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
  } bus_req_t;

  // Offset is relative to the base of the region
  typedef struct packed {
    region_e                region;
    logic [`SOC_ADDR_W-1:0] offset;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] strb;
  } dec_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

endpackage

// ==== rtl/soc_map_pkg.sv ====
// Memory map region codes and control register word offsets
`include "soc_macros.svh"

package soc_map_pkg;

  typedef enum logic [1:0] {
    REGION_L2   = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } region_e;

  // Offsets inside the control window
  typedef enum logic [`SOC_ADDR_W-1:0] {
    CTRL_EXIT      = 32'h0,
    CTRL_DRAM_BASE = 32'h4,
    CTRL_DRAM_END  = 32'h8,
    CTRL_BENCH     = 32'hC
  } ctrl_reg_e;

endpackage

// ==== rtl/soc_macros.svh ====
// Bus widths, memory map windows and memory sizes
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// Memory map
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h0000_0400
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LEN  32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h0000_1000

`define SOC_L2_WORDS    256
`define SOC_QUEUE_DEPTH 4

`endif
